/* dv/etx_core_chk.sv */
module etx_core_chk (
   input logic             clk,
   input logic             rst_n,
   input logic             tx_enable,
   input logic             arb_valid,
   input logic             rmp_valid,
   input logic             wr_ready,
   input logic             rd_ready,
   input logic             rr_ready,
   input logic             tx_access,
   input etx_pkg::packet_t tx_packet,
   input logic             tx_burst,
   input logic             tx_ack
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_cnt = 0;                    // Failed assertion count

   // Link stays quiet until enabled
   link_off: assert property (@(posedge clk) disable iff (!rst_n)
      !tx_enable |-> !tx_access)
      else begin
         $error("tx_access high while tx_enable is low");
         fail_cnt++;
      end

   // Unacked packet holds on the link
   link_hold: assert property (@(posedge clk) disable iff (!rst_n)
      tx_access && !tx_ack |=> tx_access && $stable(tx_packet) && $stable(tx_burst))
      else begin
         $error("tx_packet or tx_burst changed before tx_ack");
         fail_cnt++;
      end

   // One grant at a time
   one_grant: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({wr_ready, rd_ready, rr_ready}))
      else begin
         $error("ready high on more than one channel");
         fail_cnt++;
      end

   pipe_empty: assert property (@(posedge clk)
      $rose(rst_n) |-> !arb_valid && !rmp_valid && !tx_access)
      else begin
         $error("pipeline not empty in first cycle after reset");
         fail_cnt++;
      end

endmodule

/* dv/etx_core_tb.sv */
module etx_core_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import etx_pkg::*;

   localparam int         TIMEOUT_CYC = 2000;    // Roughly 4x the whole sequence
   localparam logic [3:0] CH_RR = 4'h1;          // Channel tag in source bits 31:28
   localparam logic [3:0] CH_RD = 4'h2;
   localparam logic [3:0] CH_WR = 4'h3;

   logic    clk = 1'b0;
   logic    rst_n;
   logic    wr_valid;
   packet_t wr_packet;
   logic    wr_ready;
   logic    rd_valid;
   packet_t rd_packet;
   logic    rd_ready;
   logic    rr_valid;
   packet_t rr_packet;
   logic    rr_ready;
   logic    tx_access;
   packet_t tx_packet;
   logic    tx_burst;
   logic    tx_ack;

   packet_t wr_q[$];                             // Waiting to be offered
   packet_t rd_q[$];
   packet_t rr_q[$];
   packet_t exp_wr[$];                           // Expected on the link per channel
   packet_t exp_rd[$];
   packet_t exp_rr[$];
   logic    wr_fire = 1'b0;                      // Handshake seen on last edge
   logic    rd_fire = 1'b0;
   logic    rr_fire = 1'b0;

   logic        remap_en = 1'b0;                 // Register model
   addr_t       mask_m = '0;
   addr_t       base_m = '0;
   logic        last_wr = 1'b0;                  // Last packet on the link
   addr_t       last_dst = '0;
   logic [15:0] seq = '0;
   logic        rand_ack = 1'b0;
   logic        prio_check = 1'b0;
   logic        lat_check = 1'b0;
   int          cyc = 0;
   int          acc_cyc = -1;                    // First rr accept in latency test
   int          xfer_cyc = -1;
   int          xfer_cnt = 0;
   int          burst_cnt = 0;
   int          sb_errors = 0;
   int          seq_errors = 0;
   packet_t     exp_pkt;
   logic [3:0]  tag;
   logic        found;
   logic        burst_exp;

   always #5 clk = ~clk;

   etx_core UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_valid  (wr_valid),
      .wr_packet (wr_packet),
      .wr_ready  (wr_ready),
      .rd_valid  (rd_valid),
      .rd_packet (rd_packet),
      .rd_ready  (rd_ready),
      .rr_valid  (rr_valid),
      .rr_packet (rr_packet),
      .rr_ready  (rr_ready),
      .tx_access (tx_access),
      .tx_packet (tx_packet),
      .tx_burst  (tx_burst),
      .tx_ack    (tx_ack)
   );

   bind etx_core etx_core_chk u_chk (
      .clk       (clk),
      .rst_n     (rst_n),
      .tx_enable (tx_enable),
      .arb_valid (arb_valid),
      .rmp_valid (rmp_valid),
      .wr_ready  (wr_ready),
      .rd_ready  (rd_ready),
      .rr_ready  (rr_ready),
      .tx_access (tx_access),
      .tx_packet (tx_packet),
      .tx_burst  (tx_burst),
      .tx_ack    (tx_ack)
   );

   function automatic packet_t make_packet(input logic wr, input addr_t dst,
                                           input addr_t data, input addr_t src);
      packet_t p;
      p                    = '0;
      p[WR_BIT]            = wr;
      p[DST_MSB:DST_LSB]   = dst;
      p[DATA_MSB:DATA_LSB] = data;
      p[SRC_MSB:SRC_LSB]   = src;
      return p;
   endfunction

   // Queue a link packet and its expected form
   task automatic send(input logic [3:0] ch, input logic wr, input addr_t dst,
                       input addr_t data);
      packet_t p;
      p   = make_packet(wr, dst, data, {ch, 12'h000, seq});
      seq = seq + 16'd1;
      case (ch)
         CH_RR:   rr_q.push_back(p);
         CH_RD:   rd_q.push_back(p);
         default: wr_q.push_back(p);
      endcase
      if (remap_en && (ch != CH_RR)) begin       // Requests only
         for (int b = 0; b < 32; b++) begin
            if (mask_m[b]) begin
               p[DST_LSB + b] = base_m[b];       // Masked bit taken from base
            end
         end
      end
      case (ch)
         CH_RR:   exp_rr.push_back(p);
         CH_RD:   exp_rd.push_back(p);
         default: exp_wr.push_back(p);
      endcase
   endtask

   // Register writes never reach the link
   task automatic reg_write(input logic [1:0] offset, input addr_t data);
      addr_t dst;
      dst = {CHIP_ID, CFG_REGION, 12'h000, offset, 2'b00};
      wr_q.push_back(make_packet(1'b1, dst, data, {CH_WR, 28'h0}));
      case (offset)
         REG_CTRL:       remap_en = data[CTRL_REMAP_EN];
         REG_REMAP_MASK: mask_m   = data;
         REG_REMAP_BASE: base_m   = data;
         default:        ;
      endcase
   endtask

   // One cycle of channel driving on the falling edge
   task automatic step();
      @(negedge clk);
      if (wr_fire) void'(wr_q.pop_front());
      if (rd_fire) void'(rd_q.pop_front());
      if (rr_fire) void'(rr_q.pop_front());
      wr_valid = (wr_q.size() != 0);
      rd_valid = (rd_q.size() != 0);
      rr_valid = (rr_q.size() != 0);
      if (wr_valid) wr_packet = wr_q[0];
      if (rd_valid) rd_packet = rd_q[0];
      if (rr_valid) rr_packet = rr_q[0];
      if (rand_ack) tx_ack = 1'($urandom & 1);   // Link back-pressure
   endtask

   task automatic wait_idle();
      while ((wr_q.size() + rd_q.size() + rr_q.size() +
              exp_wr.size() + exp_rd.size() + exp_rr.size()) != 0) begin
         step();
      end
      repeat (3) step();                         // Let register hits land
   endtask

   // Scoreboard for one link transfer
   task automatic check_transfer();
      tag   = tx_packet[SRC_MSB -: 4];
      found = 1'b0;
      if (tag == CH_RR && exp_rr.size() != 0) begin
         exp_pkt = exp_rr.pop_front();
         found   = 1'b1;
      end else if (tag == CH_RD && exp_rd.size() != 0) begin
         exp_pkt = exp_rd.pop_front();
         found   = 1'b1;
      end else if (tag == CH_WR && exp_wr.size() != 0) begin
         exp_pkt = exp_wr.pop_front();
         found   = 1'b1;
      end
      if (!found) begin
         sb_errors++;
         $display("Unexpected packet on the link at %0t, tag %h", $time, tag);
      end else begin
         burst_exp = exp_pkt[WR_BIT] && last_wr &&
                     (exp_pkt[DST_MSB:DST_LSB] == last_dst + BURST_STRIDE);
         assert (tx_packet === exp_pkt) else begin
            sb_errors++;
            $display("** Error @%0t: tx_packet expected %h got %h", $time, exp_pkt, tx_packet);
         end
         assert (tx_burst === burst_exp) else begin
            sb_errors++;
            $display("** Error @%0t: tx_burst expected %b got %b", $time, burst_exp, tx_burst);
         end
         last_wr  = exp_pkt[WR_BIT];
         last_dst = exp_pkt[DST_MSB:DST_LSB];
      end
      if (prio_check) begin                      // rr before rd before wr
         assert ((tag == CH_RR) || (exp_rr.size() == 0 &&
                 (tag == CH_RD || exp_rd.size() == 0))) else begin
            sb_errors++;
            $display("Lower priority packet left ahead of a pending one at %0t", $time);
         end
      end
      if (tx_burst) burst_cnt++;
      if (lat_check && xfer_cyc < 0) xfer_cyc = cyc;
      xfer_cnt++;
   endtask

   always @(posedge clk) begin
      cyc     <= cyc + 1;
      wr_fire <= wr_valid && wr_ready;
      rd_fire <= rd_valid && rd_ready;
      rr_fire <= rr_valid && rr_ready;
      if (lat_check && rr_valid && rr_ready && acc_cyc < 0) acc_cyc = cyc;
      if (tx_access && tx_ack) check_transfer();
   end

   initial begin
      wait (cyc >= TIMEOUT_CYC);
      $display("Timeout: traffic still pending after %0d cycles", TIMEOUT_CYC);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      void'($urandom(11));
      rst_n     = 1'b0;
      wr_valid  = 1'b0;
      rd_valid  = 1'b0;
      rr_valid  = 1'b0;
      wr_packet = '0;
      rd_packet = '0;
      rr_packet = '0;
      tx_ack    = 1'b1;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // Stalled until tx_enable
      send(CH_WR, 1'b1, 32'h1000_0100, 32'hCAFE_0001);
      repeat (12) step();
      assert (xfer_cnt == 0) else begin
         seq_errors++;
         $display("Packet reached the link while tx_enable was low");
      end
      reg_write(REG_CTRL, 32'h1);
      wait_idle();

      lat_check  = 1'b1;                         // All three channels at once
      prio_check = 1'b1;
      for (int i = 0; i < 3; i++) begin
         send(CH_WR, 1'b1, 32'h1000_0200 + addr_t'(16 * i), 32'hD000_0000 + addr_t'(i));
         send(CH_RD, 1'b0, 32'h1000_0300 + addr_t'(16 * i), '0);
         send(CH_RR, 1'b1, 32'h2000_0000 + addr_t'(256 * i), 32'hE000_0000 + addr_t'(i));
      end
      wait_idle();
      assert (xfer_cyc - acc_cyc == 3) else begin
         seq_errors++;
         $display("** Error @%0t: tx_access latency expected 3 got %0d", $time,
                  xfer_cyc - acc_cyc);
      end
      lat_check  = 1'b0;
      prio_check = 1'b0;

      reg_write(REG_REMAP_MASK, 32'h00FF_0000);
      reg_write(REG_REMAP_BASE, 32'h0055_0000);
      reg_write(REG_CTRL, 32'h3);
      wait_idle();
      for (int i = 0; i < 2; i++) begin          // rr keeps 0x10AA while requests get 0x1055
         send(CH_RR, 1'b1, 32'h10AA_0000 + addr_t'(64 * i), addr_t'(i));
         send(CH_RD, 1'b0, 32'h10AA_0000 + addr_t'(64 * i), '0);
         send(CH_WR, 1'b1, 32'h10AA_0800 + addr_t'(64 * i), addr_t'(i));
      end
      wait_idle();

      // Bursts broken by a read and by a gap
      for (int i = 0; i < 4; i++) begin
         send(CH_WR, 1'b1, 32'h3000_1000 + addr_t'(4 * i), addr_t'(i));
      end
      wait_idle();
      send(CH_RD, 1'b0, 32'h3000_2000, '0);
      wait_idle();
      send(CH_WR, 1'b1, 32'h3000_1010, 32'h10);
      send(CH_WR, 1'b1, 32'h3000_1014, 32'h14);
      send(CH_WR, 1'b1, 32'h3000_1028, 32'h28);
      wait_idle();
      assert (burst_cnt == 4) else begin
         seq_errors++;
         $display("** Error @%0t: tx_burst count expected 4 got %0d", $time, burst_cnt);
      end

      rand_ack = 1'b1;
      for (int i = 0; i < 20; i++) begin
         send(CH_RR, 1'b1, {4'h7, 28'($urandom)}, $urandom);
         send(CH_RD, 1'b0, {4'h6, 28'($urandom)}, '0);
         send(CH_WR, 1'b1, 32'h5000_0000 + addr_t'(4 * i), $urandom);
      end
      wait_idle();
      rand_ack = 1'b0;
      tx_ack   = 1'b1;

      $display("Errors: scoreboard %0d, sequence %0d, assertions %0d",
               sb_errors, seq_errors, UUT.u_chk.fail_cnt);
      if (sb_errors == 0 && seq_errors == 0 && UUT.u_chk.fail_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* hdl/etx_arbiter.sv */
module etx_arbiter (
   input  logic             clk,
   input  logic             rst_n,
   // Write requests, lowest priority
   input  logic             wr_valid,
   input  etx_pkg::packet_t wr_packet,
   output logic             wr_ready,
   // Read requests
   input  logic             rd_valid,
   input  etx_pkg::packet_t rd_packet,
   output logic             rd_ready,
   // Read responses, highest priority
   input  logic             rr_valid,
   input  etx_pkg::packet_t rr_packet,
   output logic             rr_ready,
   // Toward the config filter
   output logic             arb_valid,
   output etx_pkg::packet_t arb_packet,
   output logic             arb_rr,
   input  logic             arb_ready
);
   import etx_pkg::*;

   arb_sel_e grant;                              // Winner this cycle
   arb_sel_e sel_q;                              // Channel held in output register
   packet_t  grant_packet;                       // Packet of the winner
   logic     load;                               // Output register free or draining

   // Register can take a new packet when empty or being emptied
   assign load = (sel_q == SEL_NONE) || arb_ready;

   // Fixed priority rr > rd > wr
   always_comb begin
      grant        = SEL_NONE;
      grant_packet = wr_packet;                  // Don't care when nothing valid
      if (rr_valid) begin
         grant        = SEL_RR;
         grant_packet = rr_packet;
      end else if (rd_valid) begin
         grant        = SEL_RD;
         grant_packet = rd_packet;
      end else if (wr_valid) begin
         grant        = SEL_WR;
         grant_packet = wr_packet;
      end
   end

   // Only the granted channel sees ready
   assign rr_ready = load && (grant == SEL_RR);
   assign rd_ready = load && (grant == SEL_RD);
   assign wr_ready = load && (grant == SEL_WR);

   // Grant record doubles as the valid flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel_q <= SEL_NONE;
      end else if (load) begin
         sel_q <= grant;                         // SEL_NONE empties the stage
      end
   end

   // Payload register
   always_ff @(posedge clk) begin
      if (load && (grant != SEL_NONE)) begin
         arb_packet <= grant_packet;
      end
   end

   assign arb_valid = (sel_q != SEL_NONE);
   assign arb_rr    = (sel_q == SEL_RR);         // Marks response packets for remap bypass

endmodule

/* hdl/etx_cfg.sv */
module etx_cfg (
   input  logic             clk,
   input  logic             rst_n,
   // From the arbiter
   input  logic             arb_valid,
   input  etx_pkg::packet_t arb_packet,
   input  logic             arb_rr,
   output logic             arb_ready,
   // Toward remap
   output logic             cfg_valid,
   output etx_pkg::packet_t cfg_packet,
   output logic             cfg_rr,
   input  logic             cfg_ready,
   // Control register outputs
   output logic             tx_enable,
   output logic             remap_enable,
   output etx_pkg::addr_t   remap_mask,
   output etx_pkg::addr_t   remap_base
);
   import etx_pkg::*;

   addr_t      dst;                              // Destination of incoming packet
   addr_t      wr_data;                          // Data field of incoming packet
   logic [1:0] offset;                           // Register select
   logic       hit;                              // Write into own register space
   logic       reg_we;                           // Register write this edge
   logic [1:0] ctrl_q;                           // REG_CTRL enable bits

   assign dst     = arb_packet[DST_MSB:DST_LSB];
   assign wr_data = arb_packet[DATA_MSB:DATA_LSB];
   assign offset  = dst[3:2];

   // Register hit needs chip id, region and write flag
   assign hit = arb_packet[WR_BIT] &&
                (dst[31:20] == CHIP_ID) &&
                (dst[19:16] == CFG_REGION);

   assign reg_we = arb_valid && hit;             // Always accepted

   // Hits are consumed here, the rest passes straight through
   assign arb_ready  = hit ? 1'b1 : cfg_ready;
   assign cfg_valid  = arb_valid && !hit;
   assign cfg_packet = arb_packet;
   assign cfg_rr     = arb_rr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q     <= '0;
         remap_mask <= '0;
         remap_base <= '0;
      end else if (reg_we) begin
         case (offset)
            REG_CTRL:       ctrl_q     <= wr_data[CTRL_REMAP_EN:CTRL_TX_EN];
            REG_REMAP_MASK: remap_mask <= wr_data;
            REG_REMAP_BASE: remap_base <= wr_data;
            default:        ;                    // Undefined offset, write dropped
         endcase
      end
   end

   assign tx_enable    = ctrl_q[CTRL_TX_EN];
   assign remap_enable = ctrl_q[CTRL_REMAP_EN];

endmodule

/* hdl/etx_core.sv */
module etx_core (
   input  logic             clk,
   input  logic             rst_n,
   // Request and response channels
   input  logic             wr_valid,
   input  etx_pkg::packet_t wr_packet,
   output logic             wr_ready,
   input  logic             rd_valid,
   input  etx_pkg::packet_t rd_packet,
   output logic             rd_ready,
   input  logic             rr_valid,
   input  etx_pkg::packet_t rr_packet,
   output logic             rr_ready,
   // Link
   output logic             tx_access,
   output etx_pkg::packet_t tx_packet,
   output logic             tx_burst,
   input  logic             tx_ack
);
   import etx_pkg::*;

   logic    arb_valid;                           // Arbiter to config filter
   packet_t arb_packet;
   logic    arb_rr;
   logic    arb_ready;
   logic    cfg_valid;                           // Config filter to remap
   packet_t cfg_packet;
   logic    cfg_rr;
   logic    cfg_ready;
   logic    rmp_valid;                           // Remap to protocol
   packet_t rmp_packet;
   logic    rmp_ready;
   logic    tx_enable;                           // Control register fields
   logic    remap_enable;
   addr_t   remap_mask;
   addr_t   remap_base;

   etx_arbiter u_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_valid   (wr_valid),
      .wr_packet  (wr_packet),
      .wr_ready   (wr_ready),
      .rd_valid   (rd_valid),
      .rd_packet  (rd_packet),
      .rd_ready   (rd_ready),
      .rr_valid   (rr_valid),
      .rr_packet  (rr_packet),
      .rr_ready   (rr_ready),
      .arb_valid  (arb_valid),
      .arb_packet (arb_packet),
      .arb_rr     (arb_rr),
      .arb_ready  (arb_ready)
   );

   etx_cfg u_cfg (
      .clk          (clk),
      .rst_n        (rst_n),
      .arb_valid    (arb_valid),
      .arb_packet   (arb_packet),
      .arb_rr       (arb_rr),
      .arb_ready    (arb_ready),
      .cfg_valid    (cfg_valid),
      .cfg_packet   (cfg_packet),
      .cfg_rr       (cfg_rr),
      .cfg_ready    (cfg_ready),
      .tx_enable    (tx_enable),
      .remap_enable (remap_enable),
      .remap_mask   (remap_mask),
      .remap_base   (remap_base)
   );

   etx_remap u_remap (
      .clk          (clk),
      .rst_n        (rst_n),
      .cfg_valid    (cfg_valid),
      .cfg_packet   (cfg_packet),
      .cfg_rr       (cfg_rr),
      .cfg_ready    (cfg_ready),
      .remap_enable (remap_enable),
      .remap_mask   (remap_mask),
      .remap_base   (remap_base),
      .rmp_valid    (rmp_valid),
      .rmp_packet   (rmp_packet),
      .rmp_ready    (rmp_ready)
   );

   etx_protocol u_protocol (
      .clk        (clk),
      .rst_n      (rst_n),
      .rmp_valid  (rmp_valid),
      .rmp_packet (rmp_packet),
      .rmp_ready  (rmp_ready),
      .tx_enable  (tx_enable),
      .tx_access  (tx_access),
      .tx_packet  (tx_packet),
      .tx_burst   (tx_burst),
      .tx_ack     (tx_ack)
   );

endmodule

/* hdl/etx_pkg.sv */
package etx_pkg;

   // Link packet geometry
   localparam int PW = 104;                      // Packet width in bits

   typedef logic [PW-1:0] packet_t;              // One link packet
   typedef logic [31:0]   addr_t;                // Destination or source address

   // Field positions inside packet_t
   localparam int WR_BIT   = 0;                  // Write flag
   localparam int CTRL_LSB = 1;                  // Ctrlmode low bit
   localparam int CTRL_MSB = 4;                  // Ctrlmode high bit
   localparam int DST_LSB  = 8;                  // Destination address low bit
   localparam int DST_MSB  = 39;                 // Destination address high bit
   localparam int DATA_LSB = 40;                 // Write data low bit
   localparam int DATA_MSB = 71;                 // Write data high bit
   localparam int SRC_LSB  = 72;                 // Source address low bit
   localparam int SRC_MSB  = 103;                // Source address high bit

   // Register space decode
   localparam logic [11:0] CHIP_ID    = 12'h999; // Upper 12 address bits of this chip
   localparam logic [3:0]  CFG_REGION = 4'hF;    // Address bits 19:16 of register space

   // Register offsets on address bits 3:2
   localparam logic [1:0] REG_CTRL       = 2'd0; // Enable bits
   localparam logic [1:0] REG_REMAP_MASK = 2'd1; // Bits to replace
   localparam logic [1:0] REG_REMAP_BASE = 2'd2; // Replacement bits

   // REG_CTRL bit positions
   localparam int CTRL_TX_EN    = 0;             // Lets traffic onto the link
   localparam int CTRL_REMAP_EN = 1;             // Turns on address remap

   // Address step between two writes of one burst
   localparam addr_t BURST_STRIDE = 32'd4;

   // Channel granted by the arbiter
   typedef enum logic [1:0] {
      SEL_NONE,                                  // Output register empty
      SEL_RR,                                    // Read response
      SEL_RD,                                    // Read request
      SEL_WR                                     // Write request
   } arb_sel_e;

endpackage

/* hdl/etx_protocol.sv */
module etx_protocol (
   input  logic             clk,
   input  logic             rst_n,
   // From remap
   input  logic             rmp_valid,
   input  etx_pkg::packet_t rmp_packet,
   output logic             rmp_ready,
   input  logic             tx_enable,
   // Link side
   output logic             tx_access,
   output etx_pkg::packet_t tx_packet,
   output logic             tx_burst,
   input  logic             tx_ack
);
   import etx_pkg::*;

   addr_t new_dst;                               // Destination of incoming packet
   logic  new_wr;                                // Incoming packet is a write
   addr_t hist_dst;                              // Last destination sent on link
   logic  hist_wr;                               // Last packet sent was a write
   addr_t prev_dst;                              // Reference for burst compare
   logic  prev_wr;
   logic  tx_done;                               // Link transfer this edge
   logic  load;                                  // Link register can take a packet
   logic  burst_hit;                             // Incoming packet continues a burst

   assign tx_done = tx_access && tx_ack;

   // Hold until acked, and only move while enabled
   assign load      = tx_enable && (!tx_access || tx_ack);
   assign rmp_ready = load;

   assign new_dst = rmp_packet[DST_MSB:DST_LSB];
   assign new_wr  = rmp_packet[WR_BIT];

   // Packet leaving on this edge is the newest history
   assign prev_dst = tx_done ? tx_packet[DST_MSB:DST_LSB] : hist_dst;
   assign prev_wr  = tx_done ? tx_packet[WR_BIT] : hist_wr;

   assign burst_hit = new_wr && prev_wr && (new_dst == prev_dst + BURST_STRIDE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_access <= 1'b0;
         tx_burst  <= 1'b0;
         hist_dst  <= '0;
         hist_wr   <= 1'b0;
      end else begin
         if (load) begin
            tx_access <= rmp_valid;
            tx_burst  <= rmp_valid && burst_hit; // Idle link clears it
         end
         if (tx_done) begin
            hist_dst <= tx_packet[DST_MSB:DST_LSB];
            hist_wr  <= tx_packet[WR_BIT];
         end
      end
   end

   // Link payload
   always_ff @(posedge clk) begin
      if (load && rmp_valid) begin
         tx_packet <= rmp_packet;
      end
   end

endmodule

/* hdl/etx_remap.sv */
module etx_remap (
   input  logic             clk,
   input  logic             rst_n,
   // From the config filter
   input  logic             cfg_valid,
   input  etx_pkg::packet_t cfg_packet,
   input  logic             cfg_rr,
   output logic             cfg_ready,
   // Remap settings
   input  logic             remap_enable,
   input  etx_pkg::addr_t   remap_mask,
   input  etx_pkg::addr_t   remap_base,
   // Toward the protocol stage
   output logic             rmp_valid,
   output etx_pkg::packet_t rmp_packet,
   input  logic             rmp_ready
);
   import etx_pkg::*;

   addr_t   dst_in;                              // Original destination
   addr_t   dst_out;                             // Destination after remap
   packet_t next_packet;                         // Packet with new destination
   logic    load;                                // Stage free or draining

   assign load      = !rmp_valid || rmp_ready;
   assign cfg_ready = load;

   assign dst_in = cfg_packet[DST_MSB:DST_LSB];

   // Masked bits come from base unless the packet is a response
   always_comb begin
      dst_out = dst_in;
      if (remap_enable && !cfg_rr) begin
         dst_out = (dst_in & ~remap_mask) | (remap_base & remap_mask);
      end
      next_packet                  = cfg_packet;
      next_packet[DST_MSB:DST_LSB] = dst_out;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rmp_valid <= 1'b0;
      end else if (load) begin
         rmp_valid <= cfg_valid;
      end
   end

   // Payload register
   always_ff @(posedge clk) begin
      if (load && cfg_valid) begin
         rmp_packet <= next_packet;
      end
   end

endmodule

/* list.f */
hdl/etx_pkg.sv
hdl/etx_arbiter.sv
hdl/etx_cfg.sv
hdl/etx_remap.sv
hdl/etx_protocol.sv
hdl/etx_core.sv
dv/etx_core_chk.sv
dv/etx_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the etx_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module etx_core_tb -f list.f -o etx_core_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/etx_core_sim > sim.log 2>&1
cat sim.log
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1
